/* rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Datapath width and register count
`define RV_XLEN 32
`define RV_NUM_REGS 32

// Data RAM depth in words
`define RV_DMEM_WORDS 256

// Instruction field positions
`define RV_F_OPCODE 6:0
`define RV_F_RD 11:7
`define RV_F_FUNCT3 14:12
`define RV_F_RS1 19:15
`define RV_F_RS2 24:20

// Selects SUB and SRA
`define RV_B_ALT 30

`endif

/* rv_pkg.sv */
`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;

	// RV32I major opcodes
	typedef enum logic [6:0] {
		OP_LUI         = 7'b0110111,
		OP_AUIPC       = 7'b0010111,
		OP_JAL         = 7'b1101111,
		OP_JALR        = 7'b1100111,
		OP_BRANCH      = 7'b1100011,
		OP_LOAD        = 7'b0000011,
		OP_STORE       = 7'b0100011,
		OP_ITYPE       = 7'b0010011,
		OP_RTYPE       = 7'b0110011,
		OP_FENCE       = 7'b0001111,
		OP_ENVIRONMENT = 7'b1110011
	} opcode_e;

	typedef enum logic [1:0] {
		A_NONE = 2'd0,
		A_PC   = 2'd1,
		A_RD1  = 2'd2
	} alu_a_sel_e;

	typedef enum logic [1:0] {
		B_NONE  = 2'd0,
		B_IMM   = 2'd1,
		B_RD2   = 2'd2,
		B_SHAMT = 2'd3
	} alu_b_sel_e;

	// Register write data source
	typedef enum logic [2:0] {
		WD_NONE = 3'd0,
		WD_LUI  = 3'd1,
		WD_ALU  = 3'd2,
		WD_LINK = 3'd3,
		WD_LOAD = 3'd4
	} wd_sel_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	typedef struct packed {
		logic       jump;
		logic       branch;
		alu_a_sel_e a_sel;
		alu_b_sel_e b_sel;
		logic       rf_write;
		wd_sel_e    wd_sel;
		logic       mem_read;
		logic       mem_write;
	} ctrl_t;

	typedef struct packed {
		logic       valid;
		ctrl_t      ctrl;
		alu_op_e    alu_op;
		logic [2:0] funct3;
		logic [4:0] rd;
		word_t      rs1_val;
		word_t      rs2_val;
		word_t      imm;
		word_t      pc;
	} dec_ex_t;

	typedef struct packed {
		logic       valid;
		logic [4:0] rd;
		logic       rf_write;
		wd_sel_e    wd_sel;
		logic       mem_read;
		logic       mem_write;
		word_t      alu;
		word_t      store_data;
		word_t      imm;
		word_t      link;
	} ex_mem_t;

	typedef struct packed {
		logic       valid;
		logic [4:0] rd;
		word_t      data;
	} rf_write_t;

	typedef struct packed {
		logic  valid;
		word_t target;
	} redirect_t;

endpackage

`default_nettype wire

/* control_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module control_unit
	import rv_pkg::*;
(
	input  opcode_e    opcode,
	input  logic [2:0] funct3,
	output ctrl_t      ctrl,
	output alu_op_e    alu_op_base
);

	always_comb begin
		// Everything inactive unless the opcode says otherwise
		ctrl = '{
			jump:      1'b0,
			branch:    1'b0,
			a_sel:     A_NONE,
			b_sel:     B_NONE,
			rf_write:  1'b0,
			wd_sel:    WD_NONE,
			mem_read:  1'b0,
			mem_write: 1'b0
		};

		case (opcode)
			OP_LUI: begin
				ctrl.rf_write = 1'b1;
				ctrl.wd_sel = WD_LUI;
			end
			OP_AUIPC: begin
				// pc + upper immediate through the ALU
				ctrl.a_sel = A_PC;
				ctrl.b_sel = B_IMM;
				ctrl.rf_write = 1'b1;
				ctrl.wd_sel = WD_ALU;
			end
			OP_JAL: begin
				ctrl.jump = 1'b1;
				ctrl.a_sel = A_PC;
				ctrl.b_sel = B_IMM;
				ctrl.rf_write = 1'b1;
				ctrl.wd_sel = WD_LINK;
			end
			OP_JALR: begin
				ctrl.jump = 1'b1;
				ctrl.a_sel = A_RD1;
				ctrl.b_sel = B_IMM;
				ctrl.rf_write = 1'b1;
				ctrl.wd_sel = WD_LINK;
			end
			OP_BRANCH: begin
				ctrl.branch = 1'b1;
				ctrl.a_sel = A_RD1;
				ctrl.b_sel = B_RD2;
			end
			OP_LOAD: begin
				ctrl.a_sel = A_RD1;
				ctrl.b_sel = B_IMM;
				ctrl.rf_write = 1'b1;
				ctrl.wd_sel = WD_LOAD;
				ctrl.mem_read = 1'b1;
			end
			OP_STORE: begin
				ctrl.a_sel = A_RD1;
				ctrl.b_sel = B_IMM;
				ctrl.mem_write = 1'b1;
			end
			OP_ITYPE: begin
				ctrl.a_sel = A_RD1;
				// SRLI and SRAI carry funct7 in the immediate
				ctrl.b_sel = (funct3 == 3'b101) ? B_SHAMT : B_IMM;
				ctrl.rf_write = 1'b1;
				ctrl.wd_sel = WD_ALU;
			end
			OP_RTYPE: begin
				ctrl.a_sel = A_RD1;
				ctrl.b_sel = B_RD2;
				ctrl.rf_write = 1'b1;
				ctrl.wd_sel = WD_ALU;
			end
			default: begin
				// FENCE, ENVIRONMENT and unknown opcodes stay inactive
			end
		endcase
	end

	// Operation implied by funct3 alone
	always_comb begin
		alu_op_base = ALU_ADD;
		if (opcode == OP_ITYPE || opcode == OP_RTYPE) begin
			case (funct3)
				3'b000:  alu_op_base = ALU_ADD;
				3'b001:  alu_op_base = ALU_SLL;
				3'b010:  alu_op_base = ALU_SLT;
				3'b011:  alu_op_base = ALU_SLTU;
				3'b100:  alu_op_base = ALU_XOR;
				3'b101:  alu_op_base = ALU_SRL;
				3'b110:  alu_op_base = ALU_OR;
				default: alu_op_base = ALU_AND;
			endcase
		end
	end

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module decode_stage
	import rv_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        instr_valid,
	input  logic [31:0] instr,
	input  logic [31:0] pc,
	output logic [4:0]  rs1,
	output logic [4:0]  rs2,
	input  logic [31:0] rd1,
	input  logic [31:0] rd2,
	output dec_ex_t     dec_ex
);

	opcode_e    opcode;
	logic [2:0] funct3;
	logic [4:0] rd;
	ctrl_t      cu_ctrl;
	ctrl_t      ctrl;
	alu_op_e    alu_op_base;
	alu_op_e    alu_op;
	word_t      imm;

	assign opcode = opcode_e'(instr[`RV_F_OPCODE]);
	assign funct3 = instr[`RV_F_FUNCT3];
	assign rd = instr[`RV_F_RD];
	assign rs1 = instr[`RV_F_RS1];
	assign rs2 = instr[`RV_F_RS2];

	control_unit u_control_unit (
		.opcode      (opcode),
		.funct3      (funct3),
		.ctrl        (cu_ctrl),
		.alu_op_base (alu_op_base)
	);

	// Immediate format follows the opcode
	always_comb begin
		case (opcode)
			OP_LUI, OP_AUIPC: imm = {instr[31:12], 12'b0};
			OP_JAL: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			OP_BRANCH: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			OP_STORE: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			default: imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

	always_comb begin
		alu_op = alu_op_base;
		if (instr[`RV_B_ALT]) begin
			if (opcode == OP_RTYPE && alu_op_base == ALU_ADD)
				alu_op = ALU_SUB;
			if ((opcode == OP_RTYPE || opcode == OP_ITYPE) && alu_op_base == ALU_SRL)
				alu_op = ALU_SRA;
		end
	end

	// Writes to x0 are dropped here and nowhere else
	always_comb begin
		ctrl = cu_ctrl;
		ctrl.rf_write = cu_ctrl.rf_write && (rd != 5'd0);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_ex <= '0;
		end else begin
			dec_ex.valid <= instr_valid;
			dec_ex.ctrl <= ctrl;
			dec_ex.alu_op <= alu_op;
			dec_ex.funct3 <= funct3;
			dec_ex.rd <= rd;
			dec_ex.rs1_val <= rd1;
			dec_ex.rs2_val <= rd2;
			dec_ex.imm <= imm;
			dec_ex.pc <= pc;
		end
	end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module register_file
	import rv_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	output logic [31:0] rd1,
	output logic [31:0] rd2,
	input  rf_write_t   wr
);

	// x0 has no storage
	word_t regs [1:`RV_NUM_REGS-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < `RV_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr.valid) begin
			regs[wr.rd] <= wr.data;
		end
	end

	// Same-cycle write shows through to the read ports
	assign rd1 = (rs1 == 5'd0) ? '0 :
		(wr.valid && wr.rd == rs1) ? wr.data : regs[rs1];
	assign rd2 = (rs2 == 5'd0) ? '0 :
		(wr.valid && wr.rd == rs2) ? wr.data : regs[rs2];

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_stage
	import rv_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  dec_ex_t   dec_ex,
	output ex_mem_t   ex_mem,
	output redirect_t redirect
);

	word_t a;
	word_t b;
	word_t alu;
	logic  taken;
	logic  redirect_hit;
	word_t target;

	always_comb begin
		case (dec_ex.ctrl.a_sel)
			A_PC:    a = dec_ex.pc;
			A_RD1:   a = dec_ex.rs1_val;
			default: a = '0;
		endcase
		case (dec_ex.ctrl.b_sel)
			B_IMM:   b = dec_ex.imm;
			B_RD2:   b = dec_ex.rs2_val;
			B_SHAMT: b = {27'b0, dec_ex.imm[4:0]};
			default: b = '0;
		endcase
	end

	always_comb begin
		case (dec_ex.alu_op)
			ALU_SUB:  alu = a - b;
			ALU_SLL:  alu = a << b[4:0];
			ALU_SLT:  alu = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU: alu = {31'b0, a < b};
			ALU_XOR:  alu = a ^ b;
			ALU_SRL:  alu = a >> b[4:0];
			ALU_SRA:  alu = word_t'($signed(a) >>> b[4:0]);
			ALU_OR:   alu = a | b;
			ALU_AND:  alu = a & b;
			default:  alu = a + b;
		endcase
	end

	// Branch condition on the raw register values
	always_comb begin
		case (dec_ex.funct3)
			3'b000:  taken = dec_ex.rs1_val == dec_ex.rs2_val;
			3'b001:  taken = dec_ex.rs1_val != dec_ex.rs2_val;
			3'b100:  taken = $signed(dec_ex.rs1_val) < $signed(dec_ex.rs2_val);
			3'b101:  taken = $signed(dec_ex.rs1_val) >= $signed(dec_ex.rs2_val);
			3'b110:  taken = dec_ex.rs1_val < dec_ex.rs2_val;
			3'b111:  taken = dec_ex.rs1_val >= dec_ex.rs2_val;
			default: taken = 1'b0;
		endcase
	end

	assign redirect_hit = dec_ex.valid && (dec_ex.ctrl.jump || (dec_ex.ctrl.branch && taken));
	assign target = dec_ex.ctrl.jump ? {alu[31:1], 1'b0} : dec_ex.pc + dec_ex.imm;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
			redirect <= '0;
		end else begin
			ex_mem.valid <= dec_ex.valid;
			ex_mem.rd <= dec_ex.rd;
			ex_mem.rf_write <= dec_ex.ctrl.rf_write;
			ex_mem.wd_sel <= dec_ex.ctrl.wd_sel;
			ex_mem.mem_read <= dec_ex.ctrl.mem_read;
			ex_mem.mem_write <= dec_ex.ctrl.mem_write;
			ex_mem.alu <= alu;
			ex_mem.store_data <= dec_ex.rs2_val;
			ex_mem.imm <= dec_ex.imm;
			ex_mem.link <= dec_ex.pc + 32'd4;
			redirect.valid <= redirect_hit;
			redirect.target <= target;
		end
	end

endmodule

`default_nettype wire

/* memory_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module memory_stage
	import rv_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  ex_mem_t   ex_mem,
	output rf_write_t rf_write
);

	localparam int AW = $clog2(`RV_DMEM_WORDS);

	word_t          dmem [0:`RV_DMEM_WORDS-1];
	logic [AW-1:0]  addr;
	word_t          load_q;
	ex_mem_t        wb_q;

	// Word address, byte offset ignored
	assign addr = ex_mem.alu[AW+1:2];

	always_ff @(posedge clk) begin
		if (ex_mem.valid && ex_mem.mem_write)
			dmem[addr] <= ex_mem.store_data;
		if (ex_mem.mem_read)
			load_q <= dmem[addr];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_q <= '0;
		else
			wb_q <= ex_mem;
	end

	assign rf_write.valid = wb_q.valid && wb_q.rf_write;
	assign rf_write.rd = wb_q.rd;

	always_comb begin
		case (wb_q.wd_sel)
			WD_LUI:  rf_write.data = wb_q.imm;
			WD_ALU:  rf_write.data = wb_q.alu;
			WD_LINK: rf_write.data = wb_q.link;
			WD_LOAD: rf_write.data = load_q;
			default: rf_write.data = '0;
		endcase
	end

endmodule

`default_nettype wire

/* rv_core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_top
	import rv_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        instr_valid,
	input  logic [31:0] instr,
	input  logic [31:0] pc,
	output rf_write_t   rf_write,
	output redirect_t   redirect
);

	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [31:0] rd1;
	logic [31:0] rd2;
	dec_ex_t     dec_ex;
	ex_mem_t     ex_mem;

	decode_stage u_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.rs1         (rs1),
		.rs2         (rs2),
		.rd1         (rd1),
		.rd2         (rd2),
		.dec_ex      (dec_ex)
	);

	register_file u_regs (
		.clk   (clk),
		.rst_n (rst_n),
		.rs1   (rs1),
		.rs2   (rs2),
		.rd1   (rd1),
		.rd2   (rd2),
		.wr    (rf_write)
	);

	execute_stage u_execute (
		.clk      (clk),
		.rst_n    (rst_n),
		.dec_ex   (dec_ex),
		.ex_mem   (ex_mem),
		.redirect (redirect)
	);

	memory_stage u_memory (
		.clk      (clk),
		.rst_n    (rst_n),
		.ex_mem   (ex_mem),
		.rf_write (rf_write)
	);

endmodule

`default_nettype wire

/* rv_core_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_asserts
	import rv_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input rf_write_t rf_write,
	input redirect_t redirect
);

	valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({rf_write.valid, redirect.valid}))
		else $error("valid bit is X or Z");

	no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
		rf_write.valid |-> rf_write.rd != 5'd0)
		else $error("register write targets x0");

	// Pipeline comes out of reset empty
	idle_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !rf_write.valid && !redirect.valid)
		else $error("valid bit high right after reset");

endmodule

bind rv_core_top rv_core_asserts u_asserts (
	.clk      (clk),
	.rst_n    (rst_n),
	.rf_write (rf_write),
	.redirect (redirect)
);

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_settings.svh"

module tb_rv_core
	import rv_pkg::*;
;

	localparam int AW = $clog2(`RV_DMEM_WORDS);

	// funct3 and bit 30 per burst slot, slot 0 in the low bits
	localparam logic [29:0] RT_F3 = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
	localparam logic [9:0]  RT_ALT = 10'b0010000010;
	localparam logic [26:0] IT_F3 = {3'd5, 3'd5, 3'd1, 3'd7, 3'd6, 3'd4, 3'd3, 3'd2, 3'd0};
	localparam logic [8:0]  IT_ALT = 9'b100000000;
	localparam logic [17:0] BR_F3 = {3'd7, 3'd6, 3'd5, 3'd4, 3'd1, 3'd0};

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] pc;
	rf_write_t   rf_write;
	redirect_t   redirect;

	int          cyc = 0;
	int          issued = 0;
	logic [31:0] cur_pc = 32'h0000_1000;
	logic [31:0] rng = 32'd16;
	logic        pass_seen = 1'b0;
	logic        fail_seen = 1'b0;

	// Model state, updated in issue order
	logic [31:0] mdl_regs [0:31] = '{default: '0};
	logic [31:0] mdl_mem [0:`RV_DMEM_WORDS-1];

	rf_write_t   rf_exp[$];
	int          rf_due[$];
	string       rf_name[$];
	redirect_t   rd_exp[$];
	int          rd_due[$];
	string       rd_name[$];

	rv_core_top DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.rf_write    (rf_write),
		.redirect    (redirect)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_RTYPE};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// Expected write and redirect of one instruction
	function automatic void ref_exec(input logic [31:0] ins, input logic [31:0] ipc,
			output rf_write_t w, output redirect_t r);
		logic [4:0]    rd;
		logic [2:0]    f3;
		logic [31:0]   a;
		logic [31:0]   b;
		logic [31:0]   imm_i;
		logic [31:0]   imm_s;
		logic [31:0]   imm_b;
		logic [31:0]   imm_u;
		logic [31:0]   imm_j;
		logic [31:0]   ea;
		logic [AW-1:0] widx;
		rd = ins[11:7];
		f3 = ins[14:12];
		a = mdl_regs[ins[19:15]];
		b = mdl_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u = {ins[31:12], 12'd0};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		w = '0;
		r = '0;
		w.rd = rd;
		case (ins[6:0])
			OP_LUI: begin
				w.valid = 1'b1;
				w.data = imm_u;
			end
			OP_AUIPC: begin
				w.valid = 1'b1;
				w.data = ipc + imm_u;
			end
			OP_JAL: begin
				w.valid = 1'b1;
				w.data = ipc + 32'd4;
				r.valid = 1'b1;
				r.target = ipc + imm_j;
			end
			OP_JALR: begin
				w.valid = 1'b1;
				w.data = ipc + 32'd4;
				r.valid = 1'b1;
				r.target = (a + imm_i) & ~32'd1;
			end
			OP_BRANCH: begin
				r.valid = branch_ref(f3, a, b);
				r.target = ipc + imm_b;
			end
			OP_LOAD: begin
				ea = a + imm_i;
				widx = ea[AW+1:2];
				w.valid = 1'b1;
				w.data = mdl_mem[widx];
			end
			OP_STORE: begin
				ea = a + imm_s;
				widx = ea[AW+1:2];
				mdl_mem[widx] = b;
			end
			OP_ITYPE: begin
				w.valid = 1'b1;
				if (f3 == 3'd1 || f3 == 3'd5)
					w.data = alu_ref(f3, f3 == 3'd5 && ins[30], a, {27'd0, ins[24:20]});
				else
					w.data = alu_ref(f3, 1'b0, a, imm_i);
			end
			OP_RTYPE: begin
				w.valid = 1'b1;
				w.data = alu_ref(f3, ins[30] && (f3 == 3'd0 || f3 == 3'd5), a, b);
			end
			default: begin
				// No architectural effect
			end
		endcase
		if (rd == 5'd0)
			w.valid = 1'b0;
		if (w.valid)
			mdl_regs[rd] = w.data;
	endfunction

	task automatic stop_on_failure();
		fail_seen = 1'b1;
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_rf_write(input string name, input rf_write_t exp, input rf_write_t act);
		if (act.valid !== exp.valid ||
				(exp.valid && (act.rd !== exp.rd || act.data !== exp.data))) begin
			$display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_redirect(input string name, input redirect_t exp, input redirect_t act);
		if (act.valid !== exp.valid || (exp.valid && act.target !== exp.target)) begin
			$display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
			stop_on_failure();
		end
	endtask

	// Drive one instruction and queue what it should produce
	task automatic issue_instr(input logic [31:0] ins, input string name);
		rf_write_t w;
		redirect_t r;
		@(posedge clk);
		#10;
		instr_valid = 1'b1;
		instr = ins;
		pc = cur_pc;
		ref_exec(ins, cur_pc, w, r);
		rd_exp.push_back(r);
		rd_due.push_back(cyc + 2);
		rd_name.push_back(name);
		rf_exp.push_back(w);
		rf_due.push_back(cyc + 3);
		rf_name.push_back(name);
		cur_pc = cur_pc + 32'd4;
		issued++;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#10;
			instr_valid = 1'b0;
		end
	endtask

	// LUI then ADDI, spaced for the missing forwarding
	task automatic load_reg(input logic [4:0] r, input logic [31:0] v);
		logic [31:0] upper;
		upper = (v + 32'h800) >> 12;
		issue_instr(enc_u(upper[19:0], r, OP_LUI), "load_lui");
		idle_cycles(2);
		issue_instr(enc_i(v[11:0], r, 3'b000, r, OP_ITYPE), "load_addi");
		idle_cycles(2);
	endtask

	task automatic test_upper();
		logic [31:0] r;
		r = xorshift32();
		issue_instr(enc_u(r[31:12], 5'd1, OP_LUI), "lui");
		r = xorshift32();
		issue_instr(enc_u(r[19:0], 5'd2, OP_AUIPC), "auipc");
		idle_cycles(2);
	endtask

	task automatic test_alu();
		logic [2:0]  f3;
		logic [11:0] imm;
		logic [31:0] r;
		for (int round = 0; round < 3; round++) begin
			load_reg(5'd1, xorshift32());
			load_reg(5'd2, xorshift32());
			// Independent ops back to back
			for (int i = 0; i < 10; i++) begin
				f3 = RT_F3[i*3 +: 3];
				issue_instr(enc_r(RT_ALT[i] ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, f3,
					5'(10 + i)), "rtype");
			end
			for (int i = 0; i < 9; i++) begin
				f3 = IT_F3[i*3 +: 3];
				r = xorshift32();
				if (f3 == 3'd1 || f3 == 3'd5)
					imm = {1'b0, IT_ALT[i], 5'd0, r[4:0]};
				else
					imm = r[11:0];
				issue_instr(enc_i(imm, 5'd1, f3, 5'(20 + i), OP_ITYPE), "itype");
			end
			idle_cycles(2);
		end
	endtask

	task automatic test_mem();
		logic [31:0] r;
		r = xorshift32();
		load_reg(5'd5, {22'd0, r[9:2], 2'b00});
		load_reg(5'd6, xorshift32());
		load_reg(5'd8, xorshift32());
		issue_instr(enc_s(12'd0, 5'd6, 5'd5), "sw");
		issue_instr(enc_i(12'd0, 5'd5, 3'b010, 5'd7, OP_LOAD), "lw");
		issue_instr(enc_s(12'd12, 5'd8, 5'd5), "sw_offset");
		issue_instr(enc_i(12'd12, 5'd5, 3'b010, 5'd9, OP_LOAD), "lw_offset");
		idle_cycles(2);
	endtask

	task automatic test_branch();
		logic [31:0] r;
		logic [2:0]  f3;
		load_reg(5'd1, xorshift32());
		load_reg(5'd2, xorshift32());
		for (int i = 0; i < 6; i++) begin
			f3 = BR_F3[i*3 +: 3];
			r = xorshift32();
			issue_instr(enc_b({r[12:1], 1'b0}, 5'd2, 5'd1, f3), "branch");
			issue_instr(enc_b({r[24:13], 1'b0}, 5'd1, 5'd2, f3), "branch_swap");
			issue_instr(enc_b({r[31:20], 1'b0}, 5'd1, 5'd1, f3), "branch_same");
		end
		r = xorshift32();
		issue_instr(enc_j({r[20:1], 1'b0}, 5'd8), "jal");
		issue_instr(enc_i(r[31:20], 5'd1, 3'b000, 5'd9, OP_JALR), "jalr");
		idle_cycles(2);
	endtask

	// FENCE and ECALL carry a nonzero rd so only the opcode can suppress the write
	task automatic test_noop();
		issue_instr(enc_i(12'h0FF, 5'd0, 3'b000, 5'd3, OP_FENCE), "fence");
		issue_instr(enc_i(12'h000, 5'd0, 3'b000, 5'd4, OP_ENVIRONMENT), "ecall");
		issue_instr(enc_i(12'h123, 5'd1, 3'b000, 5'd3, 7'h7F), "unknown_opcode");
		issue_instr(enc_i(12'd5, 5'd1, 3'b000, 5'd0, OP_ITYPE), "addi_x0");
		issue_instr(enc_u(20'hABCDE, 5'd0, OP_LUI), "lui_x0");
		issue_instr(enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd0), "add_x0");
		idle_cycles(2);
	endtask

	// Cycle count and run limit
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc > issued * 4 + 50) begin
			$display("ERROR: timeout after %0d cycles with %0d instructions issued", cyc, issued);
			stop_on_failure();
		end
	end

	// Outputs are stable at the falling edge
	initial begin
		@(posedge rst_n);
		forever begin
			@(negedge clk);
			if (rd_due.size() > 0 && rd_due[0] == cyc) begin
				check_redirect(rd_name.pop_front(), rd_exp.pop_front(), redirect);
				rd_due.delete(0);
			end else begin
				check_redirect("idle", '0, redirect);
			end
			if (rf_due.size() > 0 && rf_due[0] == cyc) begin
				check_rf_write(rf_name.pop_front(), rf_exp.pop_front(), rf_write);
				rf_due.delete(0);
			end else begin
				check_rf_write("idle", '0, rf_write);
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		repeat (5) @(posedge clk);
		#10;
		rst_n = 1'b1;
		test_upper();
		test_alu();
		test_mem();
		test_branch();
		test_noop();
		idle_cycles(1);
		while (rd_due.size() > 0 || rf_due.size() > 0)
			@(posedge clk);
		@(negedge clk);
		#1;
		pass_seen = 1'b1;
		$display("*** TEST PASSED ***");
		$finish;
	end

	// Run stopped by a failed assertion
	final begin
		if (!pass_seen && !fail_seen) begin
			$display("ERROR: simulation ended before all checks completed");
			$display("*** TEST FAILED ***");
		end
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
rv_pkg.sv
control_unit.sv
decode_stage.sv
register_file.sv
execute_stage.sv
memory_stage.sv
rv_core_top.sv
rv_core_asserts.sv
tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_rv_core -f compile.f -o sim_tb; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
